// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module exec_tb \
    --Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vexec_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0

// ==== tb/exec_assertions.sv ====
`timescale 1ns/1ns

module exec_assertions (
    input logic                                                clk,
    input logic                                                rst_n,
    input logic [issue_pkg::EXECUTE_PARA-1:0]                  order,
    input issue_pkg::exec_info_s [issue_pkg::EXECUTE_PARA-1:0] exec_info,
    input result_pkg::write_d_r_s [result_pkg::WRITE_PARA-1:0] write_d_r,
    input result_pkg::j_b_info_s                               j_b_info
);

    logic oth_take;

    // ALU or move order on the other lane
    assign oth_take = order[issue_pkg::EX_OTH]
        && (exec_info[issue_pkg::EX_OTH].exec_type[issue_pkg::EXEC_TYPE_ALU]
        || exec_info[issue_pkg::EX_OTH].exec_type[issue_pkg::EXEC_TYPE_SUBST]);

    alu_done_next: assert property (@(posedge clk) disable iff (!rst_n)
        oth_take |=> write_d_r[result_pkg::WR_OTH].done)
        else $error("WR_OTH done missing one cycle after order");

    jump_write_done: assert property (@(posedge clk) disable iff (!rst_n)
        write_d_r[result_pkg::WR_JMP].done == order[issue_pkg::EX_JMP])
        else $error("WR_JMP done differs from the jump lane order");

    hazard_needs_branch: assert property (@(posedge clk) disable iff (!rst_n)
        j_b_info.branch_hazard |-> j_b_info.exec_branch)
        else $error("branch hazard without a branch order");

endmodule

bind exec exec_assertions exec_assertions_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .order     (order),
    .exec_info (exec_info),
    .write_d_r (write_d_r),
    .j_b_info  (j_b_info)
);

// ==== tb/exec_stimulus.txt ====
# lane etype func3 func7 rs1 rs2 pa_rd ctx jump rd next_pc, all hex
# lane 0 branch, 1 jump, 2 alu; jump is the expected taken flag, rd the written value
0 04 0 00 00000005 00000005 01 1 1 00000000 00000000
0 04 0 00 00000005 00000006 02 2 0 00000000 00000000
0 04 1 00 80000000 7fffffff 03 3 1 00000000 00000000
0 04 4 00 80000000 7fffffff 04 4 1 00000000 00000000
0 04 4 00 7fffffff 80000000 05 5 0 00000000 00000000
0 04 5 00 00000000 ffffffff 07 7 1 00000000 00000000
0 04 5 00 80000000 80000000 08 8 1 00000000 00000000
0 04 5 00 80000000 00000001 09 9 0 00000000 00000000
0 04 6 00 00000000 ffffffff 0a a 1 00000000 00000000
0 04 7 00 ffffffff 7fffffff 0b b 1 00000000 00000000
0 04 7 00 00000001 00000002 0c c 0 00000000 00000000
0 08 0 00 00000000 80000000 0e e 1 00000000 00000000
0 08 0 00 7fc00000 7fc00000 0f f 0 00000000 00000000
0 08 1 00 bf800000 3f800000 10 0 1 00000000 00000000
0 08 1 00 c0000000 bf800000 11 1 1 00000000 00000000
0 08 1 00 80000000 00000000 12 2 0 00000000 00000000
0 08 1 00 3f800000 7f800000 13 3 1 00000000 00000000
0 08 2 00 80000000 00000000 14 4 1 00000000 00000000
0 08 2 00 40400000 40000000 15 5 0 00000000 00000000
0 08 2 00 3f800000 7f800001 16 6 0 00000000 00000000
1 10 0 00 00001000 00000ffc 0a 0 0 00000ffc 00001000
1 10 0 00 8000fff0 00000104 3f 0 0 00000104 8000fff0
2 01 0 00 00000007 00000009 01 0 0 00000010 00000000
2 01 0 20 00000003 00000005 02 0 0 fffffffe 00000000
2 01 1 00 00000001 0000001f 03 0 0 80000000 00000000
2 01 2 00 ffffffff 00000001 04 0 0 00000001 00000000
2 01 3 00 ffffffff 00000001 05 0 0 00000000 00000000
2 01 4 00 f0f0f0f0 ff00ff00 06 0 0 0ff00ff0 00000000
2 01 5 00 80000000 00000004 07 0 0 08000000 00000000
2 01 5 20 80000000 00000004 08 0 0 f8000000 00000000
2 01 6 00 12340000 00005678 09 0 0 12345678 00000000
2 01 7 00 f0f0f0f0 ff00ff00 0a 0 0 f000f000 00000000
2 02 0 00 deadbeef 00000001 3e 0 0 deadbeef 00000000

// ==== tb/exec_tb.sv ====
`timescale 1ns/1ns

module exec_tb;

    localparam int HALF_PERIOD = 10;
    localparam int DRAIN_LIMIT = 8;

    logic                                                clk;
    logic                                                rst_n;
    logic [issue_pkg::EXECUTE_PARA-1:0]                  order;
    issue_pkg::exec_info_s [issue_pkg::EXECUTE_PARA-1:0] exec_info;
    result_pkg::write_d_r_s [result_pkg::WRITE_PARA-1:0] write_d_r;
    result_pkg::j_b_info_s                               j_b_info;

    integer                 seed;
    logic                   alu_pending;
    result_pkg::write_d_r_s alu_expected;

    exec exec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .order     (order),
        .exec_info (exec_info),
        .write_d_r (write_d_r),
        .j_b_info  (j_b_info)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    // without full, only done is meaningful
    task automatic check_write(input string name, input result_pkg::write_d_r_s expected,
                               input result_pkg::write_d_r_s actual, input logic full);
        if (full ? (actual !== expected) : (actual.done !== expected.done)) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_j_b(input result_pkg::j_b_info_s expected,
                             input result_pkg::j_b_info_s actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: j_b_info expected %h, actual %h",
                     $time, expected, actual);
            stop_with_failure();
        end
    endtask

    // junk on lanes without an order
    function automatic issue_pkg::exec_info_s noise_info();
        logic [95:0] noise;
        noise = {$random(seed), $random(seed), $random(seed)};
        return noise[$bits(issue_pkg::exec_info_s)-1:0];
    endfunction

    // WR_OTH is registered, so it answers the order of the cycle before
    task automatic next_cycle();
        @(negedge clk);
        check_write("write_d_r[WR_OTH]", alu_expected, write_d_r[result_pkg::WR_OTH],
                    alu_pending);
        alu_pending  = 1'b0;
        alu_expected = '0;
    endtask

    // lane -1 means no order at all
    task automatic apply_order(input integer lane, input issue_pkg::exec_info_s info,
                               input logic exp_jump, input issue_pkg::word_t exp_rd,
                               input issue_pkg::word_t exp_pc);
        result_pkg::j_b_info_s  jb_expected;
        result_pkg::write_d_r_s jmp_expected;
        jb_expected  = '0;
        jmp_expected = '0;
        order        = '0;
        for (int k = 0; k < issue_pkg::EXECUTE_PARA; k++) begin
            exec_info[k] = noise_info();
        end
        if (lane >= 0) begin
            order[lane]     = 1'b1;
            exec_info[lane] = info;
        end
        if (lane == issue_pkg::EX_BRC) begin
            jb_expected.exec_branch    = 1'b1;
            jb_expected.branch_context = info.contex;
            jb_expected.branch_hazard  = exp_jump;
        end else if (lane == issue_pkg::EX_JMP) begin
            jb_expected.exec_jump    = 1'b1;
            jb_expected.jump_next_pc = exp_pc;
            jmp_expected.done        = 1'b1;
            jmp_expected.pa_rd       = info.pa_rd;
            jmp_expected.rd          = exp_rd;
        end else if (lane == issue_pkg::EX_OTH) begin
            alu_pending        = 1'b1;
            alu_expected.done  = 1'b1;
            alu_expected.pa_rd = info.pa_rd;
            alu_expected.rd    = exp_rd;
        end
        // zero latency outputs sampled mid low phase
        #(HALF_PERIOD / 2);
        check_j_b(jb_expected, j_b_info);
        check_write("write_d_r[WR_JMP]", jmp_expected, write_d_r[result_pkg::WR_JMP], 1'b1);
    endtask

    initial begin
        integer                fd;
        integer                code;
        integer                gap;
        integer                lane;
        integer                prev_lane;
        integer                drain;
        logic [8*160-1:0]      line;
        issue_pkg::exec_info_s info;
        logic [7:0]            etype;
        logic [7:0]            f3;
        logic [7:0]            f7;
        logic [7:0]            prd;
        logic [7:0]            ctx;
        logic                  exp_jump;
        issue_pkg::word_t      rs1;
        issue_pkg::word_t      rs2;
        issue_pkg::word_t      exp_rd;
        issue_pkg::word_t      exp_pc;

        seed         = 24421;
        rst_n        = 1'b0;
        order        = '0;
        exec_info    = '0;
        alu_pending  = 1'b0;
        alu_expected = '0;
        prev_lane    = -1;
        info         = '0;

        // an ALU order held through reset must not raise WR_OTH done
        order[issue_pkg::EX_OTH] = 1'b1;
        exec_info[issue_pkg::EX_OTH].exec_type[issue_pkg::EXEC_TYPE_ALU] = 1'b1;
        repeat (5) begin
            next_cycle();
        end
        rst_n = 1'b1;
        order = '0;

        fd = $fopen("tb/exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/exec_stimulus.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = '0;
            code = $fgets(line, fd);
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", lane, etype, f3, f7,
                           rs1, rs2, prd, ctx, exp_jump, exp_rd, exp_pc);
            if (code == 11) begin
                // ALU runs go back to back
                if (lane != issue_pkg::EX_OTH || prev_lane != issue_pkg::EX_OTH) begin
                    gap = $unsigned($random(seed)) % 3;
                end else begin
                    gap = 0;
                end
                repeat (gap) begin
                    next_cycle();
                    apply_order(-1, '0, 1'b0, '0, '0);
                end
                info.exec_type = etype[4:0];
                info.func3     = f3[2:0];
                info.func7     = f7[6:0];
                info.pa_rd     = prd[5:0];
                info.d_rs1     = rs1;
                info.d_rs2     = rs2;
                info.contex    = ctx[3:0];
                next_cycle();
                apply_order(lane, info, exp_jump, exp_rd, exp_pc);
                prev_lane = lane;
            end else if (code > 0) begin
                $display("malformed line in tb/exec_stimulus.txt");
                stop_with_failure();
            end
        end
        $fclose(fd);

        drain = 0;
        while (alu_pending || write_d_r[result_pkg::WR_OTH].done) begin
            if (drain == DRAIN_LIMIT) begin
                $display("timed out waiting for the ALU write port to go idle");
                stop_with_failure();
            end
            next_cycle();
            apply_order(-1, '0, 1'b0, '0, '0);
            drain++;
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    order,
    input  issue_pkg::exec_type_t   exec_type,
    input  issue_pkg::func3_t       func3,
    input  issue_pkg::func7_t       func7,
    input  issue_pkg::word_t        rs1,
    input  issue_pkg::word_t        rs2,
    input  issue_pkg::preg_addr_t   pa_rd,
    output result_pkg::write_d_r_s  result
);

    logic                  is_alu;
    logic                  is_subst;
    logic                  take;
    logic [4:0]            shamt;
    issue_pkg::word_t      alu_value;
    issue_pkg::word_t      value;

    logic                  done_q;
    issue_pkg::word_t      rd_q;
    issue_pkg::preg_addr_t pa_rd_q;

    assign is_alu   = exec_type[issue_pkg::EXEC_TYPE_ALU];
    assign is_subst = exec_type[issue_pkg::EXEC_TYPE_SUBST];
    assign take     = order & (is_alu | is_subst);
    assign shamt    = rs2[4:0];

    // func7 bit 5 picks sub or sra within the RISC-V OP group
    always_comb begin
        case (func3)
            3'b000:  alu_value = func7[5] ? (rs1 - rs2) : (rs1 + rs2);
            3'b001:  alu_value = rs1 << shamt;
            3'b010:  alu_value = {31'd0, $signed(rs1) < $signed(rs2)};
            3'b011:  alu_value = {31'd0, rs1 < rs2};
            3'b100:  alu_value = rs1 ^ rs2;
            3'b101:  alu_value = func7[5] ? $unsigned($signed(rs1) >>> shamt)
                                          : (rs1 >> shamt);
            3'b110:  alu_value = rs1 | rs2;
            default: alu_value = rs1 & rs2;
        endcase
    end

    // register move passes rs1 through
    assign value = is_subst ? rs1 : alu_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= take;
        end
    end

    // destination tag travels with the data
    always_ff @(posedge clk) begin
        if (take) begin
            rd_q    <= value;
            pa_rd_q <= pa_rd;
        end
    end

    assign result.done  = done_q;
    assign result.pa_rd = pa_rd_q;
    assign result.rd    = rd_q;

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
    input  issue_pkg::func3_t func3,
    input  issue_pkg::word_t  rs1,
    input  issue_pkg::word_t  rs2,
    input  logic              is_float,
    output logic              jump
);

    logic int_eq;
    logic int_lt;
    logic int_ltu;
    logic int_result;

    logic rs1_nan;
    logic rs2_nan;
    logic both_zero;
    logic f_eq;
    logic f_lt;
    logic f_result;

    assign int_eq  = (rs1 == rs2);
    assign int_lt  = ($signed(rs1) < $signed(rs2));
    assign int_ltu = (rs1 < rs2);

    always_comb begin
        case (func3)
            3'b000:  int_result = int_eq;
            3'b001:  int_result = ~int_eq;
            3'b100:  int_result = int_lt;
            3'b101:  int_result = ~int_lt;
            3'b110:  int_result = int_ltu;
            3'b111:  int_result = ~int_ltu;
            default: int_result = 1'b0;
        endcase
    end

    // all-ones exponent, nonzero fraction
    assign rs1_nan = (rs1[30:23] == 8'hff) && (rs1[22:0] != 23'd0);
    assign rs2_nan = (rs2[30:23] == 8'hff) && (rs2[22:0] != 23'd0);

    // +0 and -0 are the same value
    assign both_zero = (rs1[30:0] == 31'd0) && (rs2[30:0] == 31'd0);
    assign f_eq      = (rs1 == rs2) || both_zero;

    // sign-magnitude ordering
    always_comb begin
        if (both_zero) begin
            f_lt = 1'b0;
        end else if (rs1[31] != rs2[31]) begin
            f_lt = rs1[31];
        end else if (rs1[31]) begin
            f_lt = (rs1[30:0] > rs2[30:0]);
        end else begin
            f_lt = (rs1[30:0] < rs2[30:0]);
        end
    end

    always_comb begin
        if (rs1_nan || rs2_nan) begin
            f_result = 1'b0;
        end else begin
            case (func3)
                3'b000:  f_result = f_eq;
                3'b001:  f_result = f_lt;
                3'b010:  f_result = f_lt | f_eq;
                default: f_result = 1'b0;
            endcase
        end
    end

    assign jump = is_float ? f_result : int_result;

endmodule

// ==== verilog/exec.sv ====
`timescale 1ns/1ns

module exec (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [issue_pkg::EXECUTE_PARA-1:0]                  order,
    input  issue_pkg::exec_info_s [issue_pkg::EXECUTE_PARA-1:0]  exec_info,
    output result_pkg::write_d_r_s [result_pkg::WRITE_PARA-1:0] write_d_r,
    output result_pkg::j_b_info_s                               j_b_info
);

    logic                   jump;
    result_pkg::write_d_r_s alu_result;

    // int or float compare on the branch lane
    branch_unit branch_i (
        .func3    (exec_info[issue_pkg::EX_BRC].func3),
        .rs1      (exec_info[issue_pkg::EX_BRC].d_rs1),
        .rs2      (exec_info[issue_pkg::EX_BRC].d_rs2),
        .is_float (exec_info[issue_pkg::EX_BRC].exec_type[issue_pkg::EXEC_TYPE_FBRANCH]),
        .jump     (jump)
    );

    alu_unit alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .order     (order[issue_pkg::EX_OTH]),
        .exec_type (exec_info[issue_pkg::EX_OTH].exec_type),
        .func3     (exec_info[issue_pkg::EX_OTH].func3),
        .func7     (exec_info[issue_pkg::EX_OTH].func7),
        .rs1       (exec_info[issue_pkg::EX_OTH].d_rs1),
        .rs2       (exec_info[issue_pkg::EX_OTH].d_rs2),
        .pa_rd     (exec_info[issue_pkg::EX_OTH].pa_rd),
        .result    (alu_result)
    );

    exec_merge merge_i (
        .order      (order),
        .exec_info  (exec_info),
        .jump       (jump),
        .alu_result (alu_result),
        .write_d_r  (write_d_r),
        .j_b_info   (j_b_info)
    );

endmodule

// ==== verilog/exec_merge.sv ====
`timescale 1ns/1ns

module exec_merge (
    input  logic [issue_pkg::EXECUTE_PARA-1:0]                        order,
    input  issue_pkg::exec_info_s [issue_pkg::EXECUTE_PARA-1:0]        exec_info,
    input  logic                                                      jump,
    input  result_pkg::write_d_r_s                                    alu_result,
    output result_pkg::write_d_r_s [result_pkg::WRITE_PARA-1:0]       write_d_r,
    output result_pkg::j_b_info_s                                     j_b_info
);

    logic                  jmp_order;
    logic                  brc_order;
    issue_pkg::exec_info_s jmp_info;
    issue_pkg::exec_info_s brc_info;

    assign jmp_order = order[issue_pkg::EX_JMP];
    assign brc_order = order[issue_pkg::EX_BRC];
    assign jmp_info  = exec_info[issue_pkg::EX_JMP];
    assign brc_info  = exec_info[issue_pkg::EX_BRC];

    // link value goes back to the register file
    always_comb begin
        write_d_r[result_pkg::WR_JMP].done = jmp_order;
        if (jmp_order) begin
            write_d_r[result_pkg::WR_JMP].pa_rd = jmp_info.pa_rd;
            write_d_r[result_pkg::WR_JMP].rd    = jmp_info.d_rs2;
        end else begin
            write_d_r[result_pkg::WR_JMP].pa_rd = '0;
            write_d_r[result_pkg::WR_JMP].rd    = '0;
        end
    end

    // already registered inside the ALU
    assign write_d_r[result_pkg::WR_OTH] = alu_result;

    always_comb begin
        j_b_info.exec_jump   = jmp_order;
        j_b_info.exec_branch = brc_order;
        // mispredict flag only for a live branch
        j_b_info.branch_hazard = brc_order & jump;
        if (jmp_order) begin
            j_b_info.jump_next_pc = jmp_info.d_rs1;
        end else begin
            j_b_info.jump_next_pc = '0;
        end
        if (brc_order) begin
            j_b_info.branch_context = brc_info.contex;
        end else begin
            j_b_info.branch_context = '0;
        end
    end

endmodule

// ==== verilog/issue_pkg.sv ====
package issue_pkg;

    // operand and field widths
    typedef logic [31:0] word_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;
    typedef logic [5:0]  preg_addr_t;
    typedef logic [3:0]  context_t;

    // one-hot operation class
    typedef logic [4:0] exec_type_t;

    // bit positions inside exec_type_t
    localparam int EXEC_TYPE_ALU     = 0;
    localparam int EXEC_TYPE_SUBST   = 1;
    localparam int EXEC_TYPE_BRANCH  = 2;
    localparam int EXEC_TYPE_FBRANCH = 3;
    localparam int EXEC_TYPE_JUMP    = 4;

    // issue lanes
    localparam int EXECUTE_PARA = 3;

    localparam int EX_BRC = 0;
    localparam int EX_JMP = 1;
    localparam int EX_OTH = 2;

    // decoded operation with its operands already read
    // contex is the speculation tag
    typedef struct packed {
        exec_type_t exec_type;
        func3_t     func3;
        func7_t     func7;
        preg_addr_t pa_rd;
        word_t      d_rs1;
        word_t      d_rs2;
        context_t   contex;
    } exec_info_s;

endpackage

// ==== verilog/result_pkg.sv ====
package result_pkg;

    // register write ports
    localparam int WRITE_PARA = 2;

    localparam int WR_JMP = 0;
    localparam int WR_OTH = 1;

    // one physical register write
    typedef struct packed {
        logic                   done;
        issue_pkg::preg_addr_t  pa_rd;
        issue_pkg::word_t       rd;
    } write_d_r_s;

    // report to the context manager
    typedef struct packed {
        logic                 exec_jump;
        issue_pkg::word_t     jump_next_pc;
        logic                 exec_branch;
        issue_pkg::context_t  branch_context;
        // taken branch means speculation went the wrong way
        logic                 branch_hazard;
    } j_b_info_s;

endpackage

// ==== vlog.f ====
verilog/issue_pkg.sv
verilog/result_pkg.sv
verilog/branch_unit.sv
verilog/alu_unit.sv
verilog/exec_merge.sv
verilog/exec.sv
tb/exec_assertions.sv
tb/exec_tb.sv
